// ==== common/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  localparam addr_t RESET_PC = 16'h0100;

  localparam int T_PER_M = 4;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } mem_wr_t;

  typedef struct packed {
    logic                   byte_en;
    cpu_isa_pkg::reg_idx_t  byte_sel;
    data_t                  byte_data;
    logic                   pair_en;
    cpu_isa_pkg::pair_idx_t pair_sel;
    addr_t                  pair_data;
  } reg_wr_t;

endpackage

// ==== common/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  typedef logic [2:0] reg_idx_t;

  localparam reg_idx_t REG_B      = 3'd0;
  localparam reg_idx_t REG_C      = 3'd1;
  localparam reg_idx_t REG_D      = 3'd2;
  localparam reg_idx_t REG_E      = 3'd3;
  localparam reg_idx_t REG_H      = 3'd4;
  localparam reg_idx_t REG_L      = 3'd5;
  localparam reg_idx_t REG_HL_MEM = 3'd6;  // operand field code for the byte at (HL).
  localparam reg_idx_t REG_A      = 3'd7;

  localparam int NUM_REG_SLOTS = 8;

  typedef logic [1:0] pair_idx_t;

  localparam pair_idx_t PAIR_BC = 2'd0;
  localparam pair_idx_t PAIR_DE = 2'd1;
  localparam pair_idx_t PAIR_HL = 2'd2;

  localparam logic [1:0] OP_GRP_MISC  = 2'b00;
  localparam logic [1:0] OP_GRP_LD    = 2'b01;
  localparam logic [2:0] OP_LO_INC_R  = 3'b100;
  localparam logic [2:0] OP_LO_DEC_R  = 3'b101;
  localparam logic [2:0] OP_LO_LD_IMM = 3'b110;
  localparam logic [3:0] OP_LO_LD_RR  = 4'h1;
  localparam logic [3:0] OP_LO_INC_RR = 4'h3;
  localparam logic [3:0] OP_LO_DEC_RR = 4'hB;
  localparam logic [7:0] OP_HALT      = 8'h76;  // sits in the LD (HL),(HL) slot.
  localparam logic [7:0] OP_LD_HL_IMM = 8'h36;

  typedef enum logic [3:0] {
    NOP,
    LD_R_R,
    LD_R_IMM,
    LD_R_HL,
    LD_HL_R,
    LD_HL_IMM,
    LD_RR_IMM,
    INC_R,
    DEC_R,
    INC_RR,
    DEC_RR
  } instr_class_t;

  typedef logic [2:0] mcycle_t;

  localparam mcycle_t MC_NOP       = 3'd1;
  localparam mcycle_t MC_LD_R_R    = 3'd1;
  localparam mcycle_t MC_INC_R     = 3'd1;
  localparam mcycle_t MC_DEC_R     = 3'd1;
  localparam mcycle_t MC_LD_R_IMM  = 3'd2;
  localparam mcycle_t MC_LD_R_HL   = 3'd2;
  localparam mcycle_t MC_LD_HL_R   = 3'd2;
  localparam mcycle_t MC_INC_RR    = 3'd2;
  localparam mcycle_t MC_DEC_RR    = 3'd2;
  localparam mcycle_t MC_LD_HL_IMM = 3'd3;
  localparam mcycle_t MC_LD_RR_IMM = 3'd3;

  typedef struct packed {
    instr_class_t cls;
    reg_idx_t     dst;
    reg_idx_t     src;
    pair_idx_t    pair;
    mcycle_t      m_cycles;
  } decoded_t;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_IMM,
    FETCH_IMM16_LO,
    FETCH_IMM16_HI,
    EXECUTE
  } cpu_state_t;

  function automatic reg_idx_t pair_hi_idx(pair_idx_t p);
    return {p, 1'b0};
  endfunction

  function automatic reg_idx_t pair_lo_idx(pair_idx_t p);
    return {p, 1'b1};
  endfunction

  // index of the last machine cycle of an instruction, counted from its fetch.
  function automatic mcycle_t exec_last_mc(decoded_t d);
    mcycle_t n_imm;
    mcycle_t exec_len;
    case (d.cls)
      LD_R_IMM, LD_HL_IMM: n_imm = 3'd1;
      LD_RR_IMM:           n_imm = 3'd2;
      default:             n_imm = 3'd0;
    endcase
    if (d.m_cycles > n_imm + 3'd1) begin
      exec_len = d.m_cycles - n_imm - 3'd1;
    end else begin
      exec_len = 3'd1;
    end
    return n_imm + exec_len;
  endfunction

endpackage

// ==== core/cpu_decoder.sv ====
`timescale 1ns/1ns

module cpu_decoder (
  input  cpu_bus_pkg::data_t    i_opcode,
  output cpu_isa_pkg::decoded_t o_dec
);
  import cpu_isa_pkg::*;

  instr_class_t cls;
  mcycle_t      m_cycles;
  reg_idx_t     dst;
  reg_idx_t     src;
  pair_idx_t    pair;

  assign dst  = i_opcode[5:3];
  assign src  = i_opcode[2:0];
  assign pair = i_opcode[5:4];

  always_comb begin
    cls = NOP;
    case (i_opcode[7:6])
      OP_GRP_LD: begin
        if (i_opcode == OP_HALT) begin
          cls = NOP;
        end else if (dst == REG_HL_MEM) begin
          cls = LD_HL_R;
        end else if (src == REG_HL_MEM) begin
          cls = LD_R_HL;
        end else begin
          cls = LD_R_R;
        end
      end
      OP_GRP_MISC: begin
        if (i_opcode == OP_LD_HL_IMM) begin
          cls = LD_HL_IMM;
        end else if (dst != REG_HL_MEM && src == OP_LO_INC_R) begin
          cls = INC_R;
        end else if (dst != REG_HL_MEM && src == OP_LO_DEC_R) begin
          cls = DEC_R;
        end else if (dst != REG_HL_MEM && src == OP_LO_LD_IMM) begin
          cls = LD_R_IMM;
        end else if (pair inside {PAIR_BC, PAIR_DE, PAIR_HL}) begin
          case (i_opcode[3:0])
            OP_LO_LD_RR:  cls = LD_RR_IMM;
            OP_LO_INC_RR: cls = INC_RR;
            OP_LO_DEC_RR: cls = DEC_RR;
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    case (cls)
      LD_R_R:    m_cycles = MC_LD_R_R;
      INC_R:     m_cycles = MC_INC_R;
      DEC_R:     m_cycles = MC_DEC_R;
      LD_R_IMM:  m_cycles = MC_LD_R_IMM;
      LD_R_HL:   m_cycles = MC_LD_R_HL;
      LD_HL_R:   m_cycles = MC_LD_HL_R;
      INC_RR:    m_cycles = MC_INC_RR;
      DEC_RR:    m_cycles = MC_DEC_RR;
      LD_HL_IMM: m_cycles = MC_LD_HL_IMM;
      LD_RR_IMM: m_cycles = MC_LD_RR_IMM;
      default:   m_cycles = MC_NOP;
    endcase
  end

  assign o_dec = '{cls: cls, dst: dst, src: src, pair: pair, m_cycles: m_cycles};

endmodule

// ==== core/cpu_execute.sv ====
`timescale 1ns/1ns

module cpu_execute (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  cpu_isa_pkg::cpu_state_t i_state,
  input  cpu_isa_pkg::mcycle_t    i_m_cycle,
  input  logic [1:0]              i_t_state,
  input  logic                    i_last_t,
  input  cpu_isa_pkg::decoded_t   i_instr,
  input  cpu_bus_pkg::data_t      i_imm,
  input  cpu_bus_pkg::addr_t      i_imm16,
  input  cpu_bus_pkg::addr_t      i_pc,
  input  cpu_bus_pkg::data_t      i_mem_rd_data,
  input  cpu_bus_pkg::data_t      i_rd_a,
  input  cpu_bus_pkg::data_t      i_rd_b,
  output cpu_isa_pkg::reg_idx_t   o_rd_a_sel,
  output cpu_isa_pkg::reg_idx_t   o_rd_b_sel,
  output cpu_bus_pkg::reg_wr_t    o_reg_wr,
  output cpu_bus_pkg::addr_t      o_mem_rd_addr,
  output cpu_bus_pkg::mem_wr_t    o_mem_wr
);
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;

  logic  exec_final;
  logic  wr_strobe;
  logic  byte_wr;
  logic  pair_wr;
  logic  mem_wr;
  logic  hl_read;
  addr_t hl_addr;
  addr_t pair_val;
  data_t byte_result;
  addr_t pair_result;

  assign exec_final = (i_state == EXECUTE) && (i_m_cycle == exec_last_mc(i_instr));
  assign wr_strobe  = exec_final && (i_t_state == 2'd0);  // all writes land in T0.

  always_comb begin
    o_rd_a_sel = REG_H;
    o_rd_b_sel = REG_L;
    if (exec_final) begin
      case (i_instr.cls)
        LD_R_R, LD_HL_R: o_rd_a_sel = i_instr.src;
        INC_R, DEC_R:    o_rd_a_sel = i_instr.dst;
        INC_RR, DEC_RR: begin
          o_rd_a_sel = pair_hi_idx(i_instr.pair);
          o_rd_b_sel = pair_lo_idx(i_instr.pair);
        end
        default: ;
      endcase
    end
  end

  // the read ports watch H and L outside the final cycle, so the final
  // cycle sees the HL value from the end of the cycle before it.
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      hl_addr <= '0;
    end else if (i_last_t && !exec_final) begin
      hl_addr <= {i_rd_a, i_rd_b};
    end
  end

  assign pair_val = {i_rd_a, i_rd_b};

  always_comb begin
    case (i_instr.cls)
      LD_R_IMM: byte_result = i_imm;
      LD_R_HL:  byte_result = i_mem_rd_data;
      INC_R:    byte_result = i_rd_a + 8'd1;  // wraps modulo 256.
      DEC_R:    byte_result = i_rd_a - 8'd1;
      default:  byte_result = i_rd_a;
    endcase
  end

  always_comb begin
    case (i_instr.cls)
      INC_RR:  pair_result = pair_val + 16'd1;
      DEC_RR:  pair_result = pair_val - 16'd1;
      default: pair_result = i_imm16;
    endcase
  end

  assign byte_wr = i_instr.cls inside {LD_R_R, LD_R_IMM, LD_R_HL, INC_R, DEC_R};
  assign pair_wr = i_instr.cls inside {LD_RR_IMM, INC_RR, DEC_RR};
  assign mem_wr  = i_instr.cls inside {LD_HL_R, LD_HL_IMM};
  assign hl_read = exec_final && (i_instr.cls == LD_R_HL);

  assign o_reg_wr = '{
    byte_en:   wr_strobe && byte_wr,
    byte_sel:  i_instr.dst,
    byte_data: byte_result,
    pair_en:   wr_strobe && pair_wr,
    pair_sel:  i_instr.pair,
    pair_data: pair_result
  };

  assign o_mem_wr = '{
    en:   wr_strobe && mem_wr,
    addr: hl_addr,
    data: (i_instr.cls == LD_HL_IMM) ? i_imm : i_rd_a
  };

  assign o_mem_rd_addr = hl_read ? hl_addr : i_pc;

endmodule

// ==== core/cpu_sequencer.sv ====
`timescale 1ns/1ns

module cpu_sequencer (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  cpu_bus_pkg::data_t      i_mem_rd_data,
  input  cpu_isa_pkg::decoded_t   i_dec,
  output cpu_bus_pkg::data_t      o_opcode,
  output cpu_isa_pkg::cpu_state_t o_state,
  output cpu_isa_pkg::mcycle_t    o_m_cycle,
  output logic [1:0]              o_t_state,
  output logic                    o_last_t,
  output cpu_isa_pkg::decoded_t   o_instr,
  output cpu_bus_pkg::data_t      o_imm,
  output cpu_bus_pkg::addr_t      o_imm16,
  output cpu_bus_pkg::addr_t      o_pc
);
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;

  cpu_state_t state;
  cpu_state_t fetch_next;
  mcycle_t    m_cycle;
  logic [1:0] t_state;
  logic       last_t;
  decoded_t   instr;
  addr_t      pc;
  data_t      imm;
  addr_t      imm16;

  assign last_t   = (t_state == 2'(T_PER_M - 1));
  assign o_opcode = i_mem_rd_data;  // decoded every clock, latched only at the end of FETCH.

  always_comb begin
    case (i_dec.cls)
      LD_R_IMM, LD_HL_IMM: fetch_next = FETCH_IMM;
      LD_RR_IMM:           fetch_next = FETCH_IMM16_LO;
      default:             fetch_next = EXECUTE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state   <= FETCH;
      t_state <= 2'd0;
      m_cycle <= 3'd0;
      pc      <= RESET_PC;
      instr   <= '0;
    end else begin
      t_state <= last_t ? 2'd0 : t_state + 2'd1;
      if (last_t) begin
        m_cycle <= m_cycle + 3'd1;
        if (state != EXECUTE) begin
          pc <= pc + 16'd1;  // every fetch state consumes one byte.
        end
        case (state)
          FETCH: begin
            instr <= i_dec;
            state <= fetch_next;
          end
          FETCH_IMM:      state <= EXECUTE;
          FETCH_IMM16_LO: state <= FETCH_IMM16_HI;
          FETCH_IMM16_HI: state <= EXECUTE;
          EXECUTE: begin
            if (m_cycle == exec_last_mc(instr)) begin
              state   <= FETCH;
              m_cycle <= 3'd0;
            end
          end
          default: state <= FETCH;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (last_t) begin
      case (state)
        FETCH_IMM:      imm         <= i_mem_rd_data;
        FETCH_IMM16_LO: imm16[7:0]  <= i_mem_rd_data;  // little endian, low byte first.
        FETCH_IMM16_HI: imm16[15:8] <= i_mem_rd_data;
        default: ;
      endcase
    end
  end

  assign o_state   = state;
  assign o_m_cycle = m_cycle;
  assign o_t_state = t_state;
  assign o_last_t  = last_t;
  assign o_instr   = instr;
  assign o_imm     = imm;
  assign o_imm16   = imm16;
  assign o_pc      = pc;

endmodule

// ==== core/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  cpu_bus_pkg::data_t   i_mem_rd_data,
  output cpu_bus_pkg::addr_t   o_mem_rd_addr,
  output cpu_bus_pkg::mem_wr_t o_mem_wr
);
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;

  data_t      opcode;
  decoded_t   dec;
  cpu_state_t state;
  mcycle_t    m_cycle;
  logic [1:0] t_state;
  logic       last_t;
  decoded_t   instr;
  data_t      imm;
  addr_t      imm16;
  addr_t      pc;
  reg_idx_t   rd_a_sel;
  reg_idx_t   rd_b_sel;
  data_t      rd_a;
  data_t      rd_b;
  reg_wr_t    reg_wr;

  cpu_sequencer u_sequencer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_mem_rd_data (i_mem_rd_data),
    .i_dec         (dec),
    .o_opcode      (opcode),
    .o_state       (state),
    .o_m_cycle     (m_cycle),
    .o_t_state     (t_state),
    .o_last_t      (last_t),
    .o_instr       (instr),
    .o_imm         (imm),
    .o_imm16       (imm16),
    .o_pc          (pc)
  );

  cpu_decoder u_decoder (
    .i_opcode (opcode),
    .o_dec    (dec)
  );

  cpu_execute u_execute (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_state       (state),
    .i_m_cycle     (m_cycle),
    .i_t_state     (t_state),
    .i_last_t      (last_t),
    .i_instr       (instr),
    .i_imm         (imm),
    .i_imm16       (imm16),
    .i_pc          (pc),
    .i_mem_rd_data (i_mem_rd_data),
    .i_rd_a        (rd_a),
    .i_rd_b        (rd_b),
    .o_rd_a_sel    (rd_a_sel),
    .o_rd_b_sel    (rd_b_sel),
    .o_reg_wr      (reg_wr),
    .o_mem_rd_addr (o_mem_rd_addr),
    .o_mem_wr      (o_mem_wr)
  );

  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rd_a_sel (rd_a_sel),
    .i_rd_b_sel (rd_b_sel),
    .i_wr       (reg_wr),
    .o_rd_a     (rd_a),
    .o_rd_b     (rd_b)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_cpu -o sim_tb_cpu
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// ==== tb.f ====
common/cpu_isa_pkg.sv
common/cpu_bus_pkg.sv
verilog/reg_file.sv
core/cpu_decoder.sv
core/cpu_sequencer.sv
core/cpu_execute.sv
core/cpu_top.sv
verif/tb_cpu.sv

// ==== verif/cpu_vectors.txt ====
// header at @000: total M-cycles (high byte, low byte), number of expected writes.
// then expected writes as addr_hi addr_lo data, in order; program bytes from @100.
@000
00 e9 2c
// immediates stored to (HL)
c0 00 11  c0 01 22  c0 02 33  c0 03 44  c0 04 77  c0 05 c0  c0 06 06
// register copies
c0 10 33  c0 11 33  c0 12 44  c0 13 77  c0 14 11  c0 15 14
// 16-bit load, (HL) seeding and readback
c1 34 14  c1 34 5a  c1 35 a5  c1 36 5a  c1 37 a5  c1 38 ab  c1 39 cd  c1 3a 02
// 8-bit increment and decrement
c2 00 00  c2 01 ff  c2 02 03  c2 03 aa  c2 04 ce  c2 00 00  c1 00 c1
// pair increment and decrement
c3 00 01  c3 01 00  c3 02 ff  c3 03 ff  c3 ff c3  c4 00 00
c4 01 00  c4 02 00  c4 03 00  c4 04 ff  00 00 3c  ff ff c3
// dropped opcodes leave registers and memory alone
c5 00 e7  c5 00 5c  c5 01 e7  c5 02 00
@100
// LD r,d8 then LD (HL),r
26 c0 2e 00 06 11 0e 22 16 33 1e 44 3e 77
70 2c 71 2c 72 2c 73 2c 77 2c 74 2c 75
// LD r,r'
4a 53 5f 78 41 2e 10 70 2c 71 2c 72 2c 73 2c 77 7d 2c 77
// LD rr,d16 and LD r,(HL)
21 34 c1 77 36 5a 11 cd ab 01 02 01 46 2c 36 a5 7e
2c 70 2c 77 2c 72 2c 73 2c 71
// INC r and DEC r
3e ff 3c 06 00 05 0c 15 1c 21 00 c2
77 2c 70 2c 71 2c 72 2c 73 2e ff 2c 75 25 74
// INC rr and DEC rr
01 ff 00 03 11 00 00 1b 21 ff c2 23 70 23 71 23 72 23 73
21 00 c4 2b 74 23 75 13 0b 23 72 23 73 23 70 23 71
21 ff ff 23 36 3c 2b 36 c3
// opcodes outside the kept set
3e 5c 21 00 c5 36 e7 31 33 3b 76 80 af 34 02 0a 22 09 e0
4e 77 2c 71 2c 70
// tail
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;
  import cpu_bus_pkg::*;

  localparam int          VEC_SIZE  = 512;
  localparam int          PROG_BASE = 'h100;
  localparam int          WR_BASE   = 3;  // first byte of the expected write list.
  localparam logic [31:0] SEED      = 32'ha84c_444e;

  logic    clk;
  logic    rst;
  data_t   mem_rd_data;
  addr_t   mem_rd_addr;
  mem_wr_t mem_wr;
  mem_wr_t pending;

  data_t       mem [2**ADDR_W];
  logic [7:0]  vec_img [VEC_SIZE];
  logic [15:0] total_m;
  int          n_writes;
  int          wr_idx;
  int          cycle_count;
  int          cycle_limit;

  cpu_top DUT (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_mem_rd_data (mem_rd_data),
    .o_mem_rd_addr (mem_rd_addr),
    .o_mem_wr      (mem_wr)
  );

  always #4 clk = ~clk;

  assign mem_rd_data = mem[mem_rd_addr];  // asynchronous read, as the core expects.

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_mem_wr(input mem_wr_t got, input mem_wr_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf(
          "error at %0t ns: write %0d went to %h with %h, expected %h with %h",
          $time, wr_idx, got.addr, got.data, exp.addr, exp.data));
    end
  endtask

  // each expected write takes three image bytes holding address high, address low and data.
  function automatic mem_wr_t expected_write(input int idx);
    int      base;
    mem_wr_t w;
    base   = WR_BASE + 3 * idx;
    w.en   = 1'b1;
    w.addr = {vec_img[9'(base)], vec_img[9'(base + 1)]};
    w.data = vec_img[9'(base + 2)];
    return w;
  endfunction

  task automatic fill_memory();
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[16'(a)] = 8'($urandom);
    end
  endtask

  task automatic load_vectors();
    for (int i = 0; i < VEC_SIZE; i++) begin
      vec_img[9'(i)] = 8'h00;
    end
    $readmemh("verif/cpu_vectors.txt", vec_img);
    total_m     = {vec_img[0], vec_img[1]};
    n_writes    = int'(vec_img[2]);
    cycle_limit = int'(total_m) * T_PER_M * 2 + 100;
    if (n_writes == 0) begin
      stop_with_failure("the vector file holds no expected memory writes");
    end
    // the program image lands on its own addresses and covers the random fill there.
    for (int a = PROG_BASE; a < VEC_SIZE; a++) begin
      mem[16'(a)] = vec_img[9'(a)];
    end
  endtask

  always @(negedge clk) begin
    if (rst && mem_wr.en) begin
      stop_with_failure("a memory write pulse appeared while reset was asserted");
    end
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    wr_idx      = 0;
    cycle_count = 0;
    pending     = '0;
    void'($urandom(SEED));
    fill_memory();
    load_vectors();

    repeat (8) @(posedge clk);
    #1 rst = 1'b0;

    @(negedge clk);
    check_addr(mem_rd_addr, addr_t'(PROG_BASE), "first fetch address");

    while (wr_idx < n_writes && cycle_count < cycle_limit) begin
      if (mem_wr.en) begin
        check_mem_wr(mem_wr, expected_write(wr_idx));
        pending = mem_wr;
        wr_idx++;
      end else begin
        pending = '0;
      end
      @(posedge clk);
      #1;
      if (pending.en) begin
        mem[pending.addr] = pending.data;  // later (HL) reads see the stored byte.
      end
      @(negedge clk);
      cycle_count++;
    end

    if (wr_idx == n_writes) begin
      $display("No errors");
      $finish;
    end else begin
      stop_with_failure($sformatf(
          "timeout after %0d clocks: only %0d of %0d expected writes occurred",
          cycle_limit, wr_idx, n_writes));
    end
  end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  cpu_isa_pkg::reg_idx_t i_rd_a_sel,
  input  cpu_isa_pkg::reg_idx_t i_rd_b_sel,
  input  cpu_bus_pkg::reg_wr_t  i_wr,
  output cpu_bus_pkg::data_t    o_rd_a,
  output cpu_bus_pkg::data_t    o_rd_b
);
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;

  // slot 6 is the (HL) operand code and is never written, so it stays zero.
  data_t    regs [NUM_REG_SLOTS];
  reg_idx_t wr_hi;
  reg_idx_t wr_lo;

  assign wr_hi = pair_hi_idx(i_wr.pair_sel);
  assign wr_lo = pair_lo_idx(i_wr.pair_sel);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      for (int i = 0; i < NUM_REG_SLOTS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (i_wr.pair_en) begin
        regs[wr_hi] <= i_wr.pair_data[15:8];
        regs[wr_lo] <= i_wr.pair_data[7:0];
      end
      if (i_wr.byte_en) begin
        regs[i_wr.byte_sel] <= i_wr.byte_data;
      end
    end
  end

  assign o_rd_a = regs[i_rd_a_sel];
  assign o_rd_b = regs[i_rd_b_sel];

endmodule
